/* sources.f */
+incdir+hdl
hdl/lv_fsm_pkg.sv
hdl/lv_reg_pkg.sv
hdl/lv_efuse_loader.sv
hdl/lv_fault_mon.sv
hdl/lv_ctrl_fsm.sv
hdl/lv_reg_if.sv
hdl/lv_core.sv
sim/tb_lv_core.sv

/* Makefile */
SIM      = verilator
TOP      = tb_lv_core
FILELIST = sources.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJDIR)

/* sim/tb_lv_core.sv */
// lv core testbench
// drives power, errors and the host bus, models the efuse macro and
// checks every control output against a cycle model on each clock

`include "lv_consts.svh"

module tb_lv_core import lv_fsm_pkg::*, lv_reg_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TMO = 200;    // cycles allowed for any wait

	logic                                i_clk;
	logic                                i_rst_n;
	logic                                i_power_on;
	logic                                i_test_mode;
	logic [`LV_ERR_NUM-1:0]             i_err_raw;
	logic                                i_reg_valid;
	logic                                o_reg_ready;
	logic                                i_reg_write;
	logic [`LV_REG_AW-1:0]              i_reg_addr;
	logic [`LV_REG_DW-1:0]              i_reg_wdata;
	logic                                o_reg_rvalid;
	logic [`LV_REG_DW-1:0]              o_reg_rdata;
	logic                                o_efuse_valid;
	logic [$clog2(`LV_EFUSE_WORDS)-1:0] o_efuse_addr;
	logic                                i_efuse_ready;
	logic [`LV_REG_DW-1:0]              i_efuse_rdata;
	logic                                o_pwm_ctrl;
	logic                                o_crc_wdg_ctrl;
	logic                                o_ow_wdg_ctrl;
	logic                                o_spi_ctrl;
	logic                                o_bist_ctrl;
	logic                                o_cfg_ctrl;
	logic                                o_ow_comm_ctrl;
	logic                                o_fsafe_ctrl;
	logic                                o_int_n;

	logic [3:0]             m_state;
	logic [9:0]             m_en;        // load_start, eight enables, int_n
	logic [`LV_ERR_NUM-1:0] m_sticky;
	logic [2:0]             m_ctrl;      // bist, cfg, normal
	logic                   m_sft;
	logic                   m_busy;
	logic                   m_loaded;
	logic [1:0]             m_cnt;
	logic                   m_rvalid;
	logic [8:0]             dut_en;
	logic [`LV_REG_DW-1:0]  rd;
	int                     err_cnt;
	int                     chk_cnt;
	int                     test_num;
	int                     test_base;
	string                  en_name [9] = '{"o_int_n", "o_fsafe_ctrl", "o_ow_comm_ctrl",
		"o_cfg_ctrl", "o_bist_ctrl", "o_spi_ctrl", "o_ow_wdg_ctrl", "o_crc_wdg_ctrl", "o_pwm_ctrl"};

	lv_core dut_i (.*);

	always #5 i_clk = ~i_clk;

	assign dut_en = {o_pwm_ctrl, o_crc_wdg_ctrl, o_ow_wdg_ctrl, o_spi_ctrl, o_bist_ctrl,
		o_cfg_ctrl, o_ow_comm_ctrl, o_fsafe_ctrl, o_int_n};

	function automatic logic [15:0] fuse_word(input logic [1:0] a);
		return 16'hc3a0 ^ (16'(a) * 16'h1357);
	endfunction

	// ==================================================
	// reference: next state and registered enables
	// ==================================================
	function automatic logic [13:0] predict(input logic [3:0] cur, input logic pwr,
			input logic tmode, input logic loaded, input logic [2:0] ctrl, input logic sft,
			input logic [3:0] cls);
		logic [3:0] nxt;
		logic       err_st;
		logic       ow_on;
		err_st = (cur == FAILSAFE) || (cur == OW_COMM_ERR) || (cur == OW_WDG_FAULT) ||
		         (cur == FAULT);
		ow_on  = (cur == WAIT) || (cur == TEST) || (cur == NORMAL) || (cur == CFG) ||
		         (cur == BIST);
		nxt = cur;
		if (!pwr)
			nxt = POWER_DOWN;
		else if (cur == POWER_DOWN)
			nxt = WAIT;
		else if (cls[3])
			nxt = FAULT;
		else if (cls[2])
			nxt = OW_WDG_FAULT;
		else if (cls[1])
			nxt = OW_COMM_ERR;
		else if (cls[0])
			nxt = FAILSAFE;
		else if (cur == WAIT) begin
			if (loaded && tmode)
				nxt = TEST;
			else if (loaded && ctrl[1])
				nxt = CFG;
			else if (loaded && ctrl[0])
				nxt = NORMAL;
		end else if (cur == NORMAL) begin
			if (sft)
				nxt = RST;
			else if (ctrl[1])
				nxt = CFG;
			else if (ctrl[2])
				nxt = BIST;
		end else if (cur == TEST)
			nxt = tmode ? cur : WAIT;
		else if (cur == CFG)
			nxt = ctrl[1] ? cur : WAIT;
		else if (cur == BIST)
			nxt = ctrl[2] ? cur : WAIT;
		else
			nxt = WAIT;    // rst and cleared error states
		return {nxt, cur == POWER_DOWN && nxt == WAIT, cur == NORMAL, cur == NORMAL,
			cur == NORMAL, cur != POWER_DOWN, cur == BIST, cur == CFG, ow_on, err_st, !err_st};
	endfunction

	always @(posedge i_clk or negedge i_rst_n) begin
		logic [13:0]            pr;
		logic [3:0]             cls;
		logic [`LV_ERR_NUM-1:0] act;
		logic [`LV_ERR_NUM-1:0] clr;
		logic                   hwr;
		logic                   hrd;
		if (!i_rst_n) begin
			m_state  = POWER_DOWN;
			m_en     = 10'b1;    // int_n idles high
			m_sticky = '0;
			m_ctrl   = '0;
			m_sft    = 1'b0;
			m_busy   = 1'b0;
			m_loaded = 1'b0;
			m_cnt    = '0;
			m_rvalid = 1'b0;
		end else begin
			cls[3] = m_sticky[HV_UV] | m_sticky[HV_OV] | m_sticky[HV_OT] | m_sticky[HV_SHORT];
			cls[2] = m_sticky[OW_WDG];
			cls[1] = m_sticky[OW_COM];
			cls[0] = |{m_sticky[SPI], m_sticky[CRC_WDG], m_sticky[PWM_DT], m_sticky[PWM_MM],
				m_sticky[LV_UV], m_sticky[LV_OV]};
			act          = i_err_raw;
			act[CRC_WDG] = i_err_raw[CRC_WDG] & m_en[7];    // watchdogs only in normal
			act[OW_WDG]  = i_err_raw[OW_WDG] & m_en[6];
			hwr = i_reg_valid & ~m_busy & i_reg_write;
			hrd = i_reg_valid & ~m_busy & ~i_reg_write;
			clr = (hwr && i_reg_addr == ERR) ? i_reg_wdata[`LV_ERR_NUM-1:0] : '0;
			pr  = predict(m_state, i_power_on, i_test_mode, m_loaded, m_ctrl, m_sft, cls);
			m_sticky = (m_sticky & ~clr) | act;
			m_rvalid = hrd;    // read data one cycle after the transfer
			m_sft    = 1'b0;
			if (hwr && i_reg_addr == CTRL) begin
				m_sft  = i_reg_wdata[SFT_RST];
				m_ctrl = i_reg_wdata[SFT_RST] ? 3'b0 :
					{i_reg_wdata[BIST_EN], i_reg_wdata[CFG_EN], i_reg_wdata[NORMAL_EN]};
			end
			if (m_en[9]) begin    // load_start
				m_busy   = 1'b1;
				m_loaded = 1'b0;
				m_cnt    = '0;
			end else if (m_busy && i_efuse_ready) begin
				m_busy   = (m_cnt != 2'd3);
				m_loaded = (m_cnt == 2'd3);
				m_cnt    = m_cnt + 2'd1;
			end
			m_state = pr[13:10];
			m_en    = pr[9:0];
		end
	end

	// efuse macro with random ready
	always @(negedge i_clk) begin
		i_efuse_ready = ($urandom % 3) != 0;
		i_efuse_rdata = fuse_word(o_efuse_addr);
	end

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic note_error(input string what);
		err_cnt++;
		$display("ERROR at %0d ns: %s", $time, what);
	endtask

	task automatic check_enables(input logic [8:0] exp);
		for (int i = 0; i < 9; i++)
			check_val(en_name[i], 16'(dut_en[i]), 16'(exp[i]));
	endtask

	// outputs are all registered, so they are settled at the falling edge
	always @(negedge i_clk) begin
		if (i_rst_n) begin
			check_enables(m_en[8:0]);
			check_val("state", 16'(dut_i.state), 16'(m_state));
			check_val("o_efuse_valid", 16'(o_efuse_valid), 16'(m_busy));
			check_val("o_efuse_addr", 16'(o_efuse_addr), 16'(m_cnt));
			check_val("o_reg_ready", 16'(o_reg_ready), 16'(!m_busy));
			check_val("o_reg_rvalid", 16'(o_reg_rvalid), 16'(m_rvalid));
		end
	end

	// ==================================================
	// host bus
	// ==================================================
	task automatic reg_write(input logic [`LV_REG_AW-1:0] addr, input logic [15:0] data);
		int n;
		i_reg_valid = 1'b1;
		i_reg_write = 1'b1;
		i_reg_addr  = addr;
		i_reg_wdata = data;
		n = 0;
		while (!o_reg_ready && n < TMO) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_reg_ready)
			note_error($sformatf("host write to address %0d never saw ready", addr));
		@(negedge i_clk);    // transfer on the edge in between
		i_reg_valid = 1'b0;
		i_reg_write = 1'b0;
	endtask

	task automatic reg_read(input logic [`LV_REG_AW-1:0] addr, output logic [15:0] data);
		int n;
		i_reg_valid = 1'b1;
		i_reg_write = 1'b0;
		i_reg_addr  = addr;
		n = 0;
		while (!o_reg_ready && n < TMO) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_reg_ready)
			note_error($sformatf("host read of address %0d never saw ready", addr));
		@(negedge i_clk);
		i_reg_valid = 1'b0;
		n = 0;
		while (!o_reg_rvalid && n < TMO) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_reg_rvalid)
			note_error($sformatf("read data for address %0d never came back", addr));
		data = o_reg_rdata;
	endtask

	task automatic wait_state(input logic [3:0] st);
		int n;
		n = 0;
		while (m_state != st && n < TMO) begin
			@(negedge i_clk);
			n++;
		end
		if (m_state != st)
			note_error($sformatf("state %0d was never reached", st));
		@(negedge i_clk);    // let the registered enables follow
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (err_cnt == test_base)
			$display("test %0d %s: ok", test_num, name);
		else
			$display("test %0d %s: %0d errors", test_num, name, err_cnt - test_base);
		test_base = err_cnt;
	endtask

	initial begin
		int         cls_bit [4];
		logic [3:0] cls_st [4];
		int         n;
		cls_bit = '{HV_OT, OW_WDG, OW_COM, LV_UV};
		cls_st  = '{FAULT, OW_WDG_FAULT, OW_COMM_ERR, FAILSAFE};
		void'($urandom(32'h665a));
		err_cnt       = 0;
		chk_cnt       = 0;
		test_num      = 0;
		test_base     = 0;
		i_clk         = 1'b0;
		i_rst_n       = 1'b0;
		i_power_on    = 1'b0;
		i_test_mode   = 1'b0;
		i_err_raw     = '0;
		i_reg_valid   = 1'b0;
		i_reg_write   = 1'b0;
		i_reg_addr    = '0;
		i_reg_wdata   = '0;
		i_efuse_ready = 1'b0;
		i_efuse_rdata = '0;
		repeat (4) @(negedge i_clk);
		i_rst_n = 1'b1;

		check_enables(9'b1);
		i_power_on = 1'b1;
		wait_state(WAIT);
		check_val("o_spi_ctrl", 16'(o_spi_ctrl), 16'd1);
		check_val("o_ow_comm_ctrl", 16'(o_ow_comm_ctrl), 16'd1);
		n = 0;
		while (!m_loaded && n < TMO) begin
			@(negedge i_clk);
			n++;
		end
		if (!m_loaded)
			note_error("efuse load did not finish");
		for (int i = 0; i < `LV_EFUSE_WORDS; i++) begin
			reg_read(3'(TRIM0 + i), rd);
			check_val($sformatf("TRIM%0d", i), rd, fuse_word(2'(i)));
		end
		end_test("power-up and trim load");

		reg_write(CTRL, 16'(1 << NORMAL_EN));
		wait_state(NORMAL);
		reg_read(STATUS, rd);
		check_val("STATUS", rd, 16'(NORMAL));
		check_val("o_pwm_ctrl", 16'(o_pwm_ctrl), 16'd1);
		check_val("o_crc_wdg_ctrl", 16'(o_crc_wdg_ctrl), 16'd1);
		check_val("o_ow_wdg_ctrl", 16'(o_ow_wdg_ctrl), 16'd1);
		end_test("normal mode");

		for (int k = 0; k < 4; k++) begin
			reg_write(CTRL, 16'(1 << NORMAL_EN));
			wait_state(NORMAL);
			i_err_raw = 12'(1) << cls_bit[k];
			wait_state(cls_st[k]);
			check_val("o_fsafe_ctrl", 16'(o_fsafe_ctrl), 16'd1);
			check_val("o_int_n", 16'(o_int_n), 16'd0);
			reg_read(ERR, rd);
			check_val($sformatf("ERR bit %0d", cls_bit[k]), 16'(rd[cls_bit[k]]), 16'd1);
			i_err_raw = '0;
			reg_write(CTRL, 16'd0);    // stay in wait after the clear
			reg_write(ERR, 16'(1 << cls_bit[k]));
			wait_state(WAIT);
			reg_read(STATUS, rd);
			check_val("STATUS", rd, 16'(WAIT));
		end
		i_err_raw = 12'(1) << OW_WDG;    // watchdog is off in wait
		repeat (4) @(negedge i_clk);
		reg_read(STATUS, rd);
		check_val("STATUS", rd, 16'(WAIT));
		reg_read(ERR, rd);
		check_val("ERR bit 1", 16'(rd[OW_WDG]), 16'd0);
		i_err_raw = '0;
		end_test("error classes");

		reg_write(CTRL, 16'(1 << CFG_EN));
		wait_state(CFG);
		reg_write(TRIM1, 16'hbeef);
		reg_read(TRIM1, rd);
		check_val("TRIM1", rd, 16'hbeef);
		reg_write(CTRL, 16'(1 << NORMAL_EN));
		wait_state(NORMAL);
		reg_write(TRIM2, 16'h1234);
		reg_read(TRIM2, rd);
		check_val("TRIM2", rd, fuse_word(2'd2));
		end_test("trim write access");

		reg_write(CTRL, 16'((1 << NORMAL_EN) | (1 << BIST_EN)));
		wait_state(BIST);
		check_val("o_bist_ctrl", 16'(o_bist_ctrl), 16'd1);
		reg_write(CTRL, 16'(1 << NORMAL_EN));
		wait_state(NORMAL);
		reg_write(CTRL, 16'((1 << NORMAL_EN) | (1 << SFT_RST)));
		wait_state(RST);
		wait_state(WAIT);
		reg_read(CTRL, rd);
		check_val("CTRL", rd, 16'd0);
		i_power_on = 1'b0;
		wait_state(POWER_DOWN);
		check_enables(9'b1);
		end_test("bist, soft reset and power-down");

		$display("tests %0d, checks %0d, errors %0d", test_num, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* hdl/lv_core.sv */
// lv control core
// efuse loader, fault monitor, control FSM and host registers

`include "lv_consts.svh"

module lv_core import lv_fsm_pkg::*; (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic                                i_power_on,
	input  logic                                i_test_mode,
	input  logic [`LV_ERR_NUM-1:0]             i_err_raw,
	input  logic                                i_reg_valid,
	output logic                                o_reg_ready,
	input  logic                                i_reg_write,
	input  logic [`LV_REG_AW-1:0]              i_reg_addr,
	input  logic [`LV_REG_DW-1:0]              i_reg_wdata,
	output logic                                o_reg_rvalid,
	output logic [`LV_REG_DW-1:0]              o_reg_rdata,
	output logic                                o_efuse_valid,
	output logic [$clog2(`LV_EFUSE_WORDS)-1:0] o_efuse_addr,
	input  logic                                i_efuse_ready,
	input  logic [`LV_REG_DW-1:0]              i_efuse_rdata,
	output logic                                o_pwm_ctrl,
	output logic                                o_crc_wdg_ctrl,
	output logic                                o_ow_wdg_ctrl,
	output logic                                o_spi_ctrl,
	output logic                                o_bist_ctrl,
	output logic                                o_cfg_ctrl,
	output logic                                o_ow_comm_ctrl,
	output logic                                o_fsafe_ctrl,
	output logic                                o_int_n
);

	logic                                load_start;
	logic                                trim_loaded;
	logic                                busy;
	logic                                trim_we;
	logic [$clog2(`LV_EFUSE_WORDS)-1:0] trim_idx;
	logic [`LV_REG_DW-1:0]              trim_data;
	logic                                normal_en;
	logic                                cfg_en;
	logic                                bist_en;
	logic                                sft_rst;
	logic                                err_clr_we;
	logic [`LV_ERR_NUM-1:0]             err_clr_mask;
	logic [`LV_ERR_NUM-1:0]             err_sticky;
	logic                                cls_fault;
	logic                                cls_ow_wdg;
	logic                                cls_ow_comm;
	logic                                cls_fsafe;
	lv_state_e                           state;

	lv_efuse_loader efuse_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_load_start(load_start),
		.o_efuse_valid(o_efuse_valid), .o_efuse_addr(o_efuse_addr),
		.i_efuse_ready(i_efuse_ready), .i_efuse_rdata(i_efuse_rdata),
		.o_trim_we(trim_we), .o_trim_idx(trim_idx), .o_trim_data(trim_data),
		.o_busy(busy), .o_trim_loaded(trim_loaded)
	);

	lv_fault_mon fault_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_err_raw(i_err_raw),
		.i_crc_wdg_ctrl(o_crc_wdg_ctrl), .i_ow_wdg_ctrl(o_ow_wdg_ctrl),
		.i_err_clr_we(err_clr_we), .i_err_clr_mask(err_clr_mask),
		.o_err_sticky(err_sticky), .o_cls_fault(cls_fault), .o_cls_ow_wdg(cls_ow_wdg),
		.o_cls_ow_comm(cls_ow_comm), .o_cls_fsafe(cls_fsafe)
	);

	lv_ctrl_fsm fsm_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_power_on(i_power_on),
		.i_test_mode(i_test_mode), .i_trim_loaded(trim_loaded),
		.i_normal_en(normal_en), .i_cfg_en(cfg_en), .i_bist_en(bist_en),
		.i_sft_rst(sft_rst), .i_cls_fault(cls_fault), .i_cls_ow_wdg(cls_ow_wdg),
		.i_cls_ow_comm(cls_ow_comm), .i_cls_fsafe(cls_fsafe),
		.o_state(state), .o_load_start(load_start),
		.o_pwm_ctrl(o_pwm_ctrl), .o_crc_wdg_ctrl(o_crc_wdg_ctrl),
		.o_ow_wdg_ctrl(o_ow_wdg_ctrl), .o_spi_ctrl(o_spi_ctrl),
		.o_bist_ctrl(o_bist_ctrl), .o_cfg_ctrl(o_cfg_ctrl),
		.o_ow_comm_ctrl(o_ow_comm_ctrl), .o_fsafe_ctrl(o_fsafe_ctrl), .o_int_n(o_int_n)
	);

	lv_reg_if reg_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_reg_valid(i_reg_valid),
		.o_reg_ready(o_reg_ready), .i_reg_write(i_reg_write), .i_reg_addr(i_reg_addr),
		.i_reg_wdata(i_reg_wdata), .o_reg_rvalid(o_reg_rvalid), .o_reg_rdata(o_reg_rdata),
		.i_busy(busy), .i_trim_we(trim_we), .i_trim_idx(trim_idx), .i_trim_data(trim_data),
		.i_state(state), .i_cfg_ctrl(o_cfg_ctrl), .i_err_sticky(err_sticky),
		.o_normal_en(normal_en), .o_cfg_en(cfg_en), .o_bist_en(bist_en),
		.o_sft_rst(sft_rst), .o_err_clr_we(err_clr_we), .o_err_clr_mask(err_clr_mask)
	);

endmodule

/* hdl/lv_reg_if.sv */
// lv host register block
// CTRL, STATUS, ERR and trim registers behind a valid/ready bus

`include "lv_consts.svh"

module lv_reg_if import lv_fsm_pkg::*, lv_reg_pkg::*; (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic                                i_reg_valid,
	output logic                                o_reg_ready,
	input  logic                                i_reg_write,
	input  logic [`LV_REG_AW-1:0]              i_reg_addr,
	input  logic [`LV_REG_DW-1:0]              i_reg_wdata,
	output logic                                o_reg_rvalid,
	output logic [`LV_REG_DW-1:0]              o_reg_rdata,
	input  logic                                i_busy,
	input  logic                                i_trim_we,
	input  logic [$clog2(`LV_EFUSE_WORDS)-1:0] i_trim_idx,
	input  logic [`LV_REG_DW-1:0]              i_trim_data,
	input  lv_state_e                           i_state,
	input  logic                                i_cfg_ctrl,
	input  logic [`LV_ERR_NUM-1:0]             i_err_sticky,
	output logic                                o_normal_en,
	output logic                                o_cfg_en,
	output logic                                o_bist_en,
	output logic                                o_sft_rst,
	output logic                                o_err_clr_we,
	output logic [`LV_ERR_NUM-1:0]             o_err_clr_mask
);

	localparam int DW = `LV_REG_DW;
	localparam int IW = $clog2(`LV_EFUSE_WORDS);

	logic          xfer;
	logic          wr;
	logic          rd;
	logic          wr_trim;
	lv_reg_addr_e  addr;
	logic [2:0]    ctrl_q;               // bist, cfg, normal
	logic          sft_rst_q;
	logic [DW-1:0] trim_q [`LV_EFUSE_WORDS];
	logic [DW-1:0] rd_word;

	assign o_reg_ready = ~i_busy;    // held off during the efuse load
	assign xfer        = i_reg_valid & o_reg_ready;
	assign wr          = xfer & i_reg_write;
	assign rd          = xfer & ~i_reg_write;
	assign addr        = lv_reg_addr_e'(i_reg_addr);
	assign wr_trim     = wr & i_reg_addr[`LV_REG_AW-1] & i_cfg_ctrl;    // trim only in cfg

	// ==================================================
	// CTRL
	// ==================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ctrl_q    <= '0;
			sft_rst_q <= 1'b0;
		end else begin
			sft_rst_q <= 1'b0;
			if (wr && addr == CTRL) begin
				sft_rst_q <= i_reg_wdata[SFT_RST];
				if (i_reg_wdata[SFT_RST])
					ctrl_q <= '0;    // soft reset wipes the mode bits
				else
					ctrl_q <= {i_reg_wdata[BIST_EN], i_reg_wdata[CFG_EN], i_reg_wdata[NORMAL_EN]};
			end
		end
	end

	assign o_normal_en = ctrl_q[0];
	assign o_cfg_en    = ctrl_q[1];
	assign o_bist_en   = ctrl_q[2];
	assign o_sft_rst   = sft_rst_q;

	// w1c strobe goes straight to the fault monitor
	assign o_err_clr_we   = wr && (addr == ERR);
	assign o_err_clr_mask = i_reg_wdata[`LV_ERR_NUM-1:0];

	// loader has priority over the host
	always_ff @(posedge i_clk) begin
		if (i_trim_we)
			trim_q[i_trim_idx] <= i_trim_data;
		else if (wr_trim)
			trim_q[i_reg_addr[IW-1:0]] <= i_reg_wdata;
	end

	// ==================================================
	// read path
	// ==================================================
	always_comb begin
		rd_word = '0;
		case (addr)
			CTRL:                      rd_word = DW'(ctrl_q);
			STATUS:                    rd_word = DW'(i_state);
			ERR:                       rd_word = DW'(i_err_sticky);
			TRIM0, TRIM1, TRIM2, TRIM3: rd_word = trim_q[i_reg_addr[IW-1:0]];
			default:                   rd_word = '0;    // hole at 3
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_reg_rvalid <= 1'b0;
		else
			o_reg_rvalid <= rd;
	end

	always_ff @(posedge i_clk) begin
		if (rd)
			o_reg_rdata <= rd_word;
	end

endmodule

/* hdl/lv_ctrl_fsm.sv */
// lv control FSM
// picks the operating mode from power, fault classes and host
// commands, and drives the registered block enables

module lv_ctrl_fsm import lv_fsm_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_power_on,
	input  logic      i_test_mode,
	input  logic      i_trim_loaded,
	input  logic      i_normal_en,
	input  logic      i_cfg_en,
	input  logic      i_bist_en,
	input  logic      i_sft_rst,
	input  logic      i_cls_fault,
	input  logic      i_cls_ow_wdg,
	input  logic      i_cls_ow_comm,
	input  logic      i_cls_fsafe,
	output lv_state_e o_state,
	output logic      o_load_start,
	output logic      o_pwm_ctrl,
	output logic      o_crc_wdg_ctrl,
	output logic      o_ow_wdg_ctrl,
	output logic      o_spi_ctrl,
	output logic      o_bist_ctrl,
	output logic      o_cfg_ctrl,
	output logic      o_ow_comm_ctrl,
	output logic      o_fsafe_ctrl,
	output logic      o_int_n
);

	lv_state_e cur_st;
	lv_state_e nxt_st;
	logic      load_go;
	logic      st_err;
	logic      st_ow_on;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			cur_st <= POWER_DOWN;
		else
			cur_st <= nxt_st;
	end

	// ==================================================
	// next state
	// ==================================================
	always_comb begin
		nxt_st = cur_st;
		if (!i_power_on)
			nxt_st = POWER_DOWN;
		else if (cur_st == POWER_DOWN)
			nxt_st = WAIT;
		else if (i_cls_fault)    // classes beat host commands
			nxt_st = FAULT;
		else if (i_cls_ow_wdg)
			nxt_st = OW_WDG_FAULT;
		else if (i_cls_ow_comm)
			nxt_st = OW_COMM_ERR;
		else if (i_cls_fsafe)
			nxt_st = FAILSAFE;
		else begin
			case (cur_st)
				WAIT: begin
					if (i_trim_loaded) begin    // no mode before trim is in
						if (i_test_mode)
							nxt_st = TEST;
						else if (i_cfg_en)
							nxt_st = CFG;
						else if (i_normal_en)
							nxt_st = NORMAL;
					end
				end
				NORMAL: begin
					if (i_sft_rst)
						nxt_st = RST;
					else if (i_cfg_en)
						nxt_st = CFG;
					else if (i_bist_en)
						nxt_st = BIST;
				end
				TEST: nxt_st = i_test_mode ? TEST : WAIT;
				CFG:  nxt_st = i_cfg_en ? CFG : WAIT;
				BIST: nxt_st = i_bist_en ? BIST : WAIT;
				// rst and cleared error states
				RST, FAILSAFE, OW_COMM_ERR, OW_WDG_FAULT, FAULT: nxt_st = WAIT;
				default: nxt_st = cur_st;
			endcase
		end
	end

	// first wait cycle after power-up kicks the efuse load
	assign load_go = (cur_st == POWER_DOWN) && (nxt_st == WAIT);

	assign st_err   = cur_st inside {FAILSAFE, OW_COMM_ERR, OW_WDG_FAULT, FAULT};
	assign st_ow_on = cur_st inside {WAIT, TEST, NORMAL, CFG, BIST};

	// ==================================================
	// registered outputs
	// ==================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_load_start   <= 1'b0;
			o_pwm_ctrl     <= 1'b0;
			o_crc_wdg_ctrl <= 1'b0;
			o_ow_wdg_ctrl  <= 1'b0;
			o_spi_ctrl     <= 1'b0;
			o_bist_ctrl    <= 1'b0;
			o_cfg_ctrl     <= 1'b0;
			o_ow_comm_ctrl <= 1'b0;
			o_fsafe_ctrl   <= 1'b0;
			o_int_n        <= 1'b1;
		end else begin
			o_load_start   <= load_go;
			o_pwm_ctrl     <= (cur_st == NORMAL);
			o_crc_wdg_ctrl <= (cur_st == NORMAL);
			o_ow_wdg_ctrl  <= (cur_st == NORMAL);
			o_spi_ctrl     <= (cur_st != POWER_DOWN);    // host link up once powered
			o_bist_ctrl    <= (cur_st == BIST);
			o_cfg_ctrl     <= (cur_st == CFG);
			o_ow_comm_ctrl <= st_ow_on;
			o_fsafe_ctrl   <= st_err;
			o_int_n        <= ~st_err;    // active low
		end
	end

	assign o_state = cur_st;

endmodule

/* hdl/lv_fault_mon.sv */
// lv fault monitor
// latches raw lv/hv error reports into sticky flags and sorts
// them into the four fault classes seen by the control FSM

`include "lv_consts.svh"

module lv_fault_mon import lv_fsm_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic [`LV_ERR_NUM-1:0] i_err_raw,
	input  logic                   i_crc_wdg_ctrl,
	input  logic                   i_ow_wdg_ctrl,
	input  logic                   i_err_clr_we,
	input  logic [`LV_ERR_NUM-1:0] i_err_clr_mask,
	output logic [`LV_ERR_NUM-1:0] o_err_sticky,
	output logic                   o_cls_fault,
	output logic                   o_cls_ow_wdg,
	output logic                   o_cls_ow_comm,
	output logic                   o_cls_fsafe
);

	logic [`LV_ERR_NUM-1:0] en_mask;
	logic [`LV_ERR_NUM-1:0] err_act;
	logic [`LV_ERR_NUM-1:0] clr;
	logic [`LV_ERR_NUM-1:0] sticky_q;
	logic [3:0]             cls;

	// watchdogs only count while their block is enabled
	always_comb begin
		en_mask          = '1;
		en_mask[CRC_WDG] = i_crc_wdg_ctrl;
		en_mask[OW_WDG]  = i_ow_wdg_ctrl;
	end

	assign err_act = i_err_raw & en_mask;
	assign clr     = i_err_clr_we ? i_err_clr_mask : '0;

	// a live error wins over the clear
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			sticky_q <= '0;
		else
			sticky_q <= (sticky_q & ~clr) | err_act;
	end

	// ==================================================
	// fault classes
	// ==================================================
	always_comb begin
		cls              = '0;
		cls[CLS_FAULT]   = sticky_q[HV_UV] | sticky_q[HV_OV] |
		                   sticky_q[HV_OT] | sticky_q[HV_SHORT];
		cls[CLS_OW_WDG]  = sticky_q[OW_WDG];
		cls[CLS_OW_COMM] = sticky_q[OW_COM];
		cls[CLS_FSAFE]   = sticky_q[SPI] | sticky_q[CRC_WDG] |
		                   sticky_q[PWM_DT] | sticky_q[PWM_MM] |
		                   sticky_q[LV_UV] | sticky_q[LV_OV];    // lv side and bus errors
	end

	assign o_err_sticky  = sticky_q;
	assign o_cls_fault   = cls[CLS_FAULT];
	assign o_cls_ow_wdg  = cls[CLS_OW_WDG];
	assign o_cls_ow_comm = cls[CLS_OW_COMM];
	assign o_cls_fsafe   = cls[CLS_FSAFE];

endmodule

/* hdl/lv_efuse_loader.sv */
// lv efuse loader
// walks the efuse macro once per load request and forwards each
// accepted word as a trim register write

`include "lv_consts.svh"

module lv_efuse_loader (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic                                i_load_start,
	output logic                                o_efuse_valid,
	output logic [$clog2(`LV_EFUSE_WORDS)-1:0] o_efuse_addr,
	input  logic                                i_efuse_ready,
	input  logic [`LV_REG_DW-1:0]              i_efuse_rdata,
	output logic                                o_trim_we,
	output logic [$clog2(`LV_EFUSE_WORDS)-1:0] o_trim_idx,
	output logic [`LV_REG_DW-1:0]              o_trim_data,
	output logic                                o_busy,
	output logic                                o_trim_loaded
);

	localparam int IW = $clog2(`LV_EFUSE_WORDS);

	logic          busy_q;
	logic          loaded_q;
	logic [IW-1:0] cnt_q;    // current efuse word
	logic          xfer;
	logic          last;

	assign xfer = busy_q & i_efuse_ready;
	assign last = (cnt_q == IW'(`LV_EFUSE_WORDS - 1));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy_q   <= 1'b0;
			loaded_q <= 1'b0;
			cnt_q    <= '0;
		end else if (i_load_start) begin    // restart from word 0
			busy_q   <= 1'b1;
			loaded_q <= 1'b0;
			cnt_q    <= '0;
		end else if (xfer) begin
			cnt_q <= last ? '0 : cnt_q + 1'b1;
			if (last) begin
				busy_q   <= 1'b0;
				loaded_q <= 1'b1;
			end
		end
	end

	assign o_efuse_valid = busy_q;
	assign o_efuse_addr  = cnt_q;
	assign o_trim_we     = xfer;            // same edge as the efuse transfer
	assign o_trim_idx    = cnt_q;
	assign o_trim_data   = i_efuse_rdata;
	assign o_busy        = busy_q;
	assign o_trim_loaded = loaded_q;

endmodule

/* hdl/lv_reg_pkg.sv */
// lv host register map
// register addresses and control register bit positions

`include "lv_consts.svh"

package lv_reg_pkg;

	typedef enum logic [`LV_REG_AW-1:0] {
		CTRL   = 3'd0,
		STATUS = 3'd1,
		ERR    = 3'd2,
		TRIM0  = 3'd4,    // trim block is aligned on 4
		TRIM1  = 3'd5,
		TRIM2  = 3'd6,
		TRIM3  = 3'd7
	} lv_reg_addr_e;

	// CTRL bit positions
	localparam int NORMAL_EN = 0;
	localparam int CFG_EN    = 1;
	localparam int BIST_EN   = 2;
	localparam int SFT_RST   = 3;

endpackage

/* hdl/lv_fsm_pkg.sv */
// lv control FSM types
// operating state encoding, raw error indices and fault classes

`include "lv_consts.svh"

package lv_fsm_pkg;

	typedef enum logic [3:0] {
		POWER_DOWN   = 4'd0,
		WAIT         = 4'd1,
		TEST         = 4'd2,
		NORMAL       = 4'd3,
		FAILSAFE     = 4'd4,
		OW_COMM_ERR  = 4'd5,
		OW_WDG_FAULT = 4'd6,
		FAULT        = 4'd7,
		CFG          = 4'd8,
		RST          = 4'd9,
		BIST         = 4'd10
	} lv_state_e;

	// positions in the raw error vector
	typedef enum logic [$clog2(`LV_ERR_NUM)-1:0] {
		OW_COM, OW_WDG, SPI, CRC_WDG, PWM_DT, PWM_MM,
		LV_UV, LV_OV, HV_UV, HV_OV, HV_OT, HV_SHORT    // hv_short = oc | desat | scp
	} lv_err_bit_e;

	typedef enum logic [1:0] {
		CLS_FAULT, CLS_OW_WDG, CLS_OW_COMM, CLS_FSAFE
	} lv_fault_cls_e;

endpackage

/* hdl/lv_consts.svh */
// lv core constants
// widths and counts shared by the low-voltage control core

`ifndef LV_CONSTS_SVH
`define LV_CONSTS_SVH

// ==================================================
// host register bus
// ==================================================
`define LV_REG_AW 3          // register address bits
`define LV_REG_DW 16         // register data bits

`define LV_EFUSE_WORDS 4     // trim words held in efuse
`define LV_ERR_NUM 12        // raw error inputs

`endif
